// ==== hdl/core_cfg_pkg.sv ====
// Machine configuration for the renaming core
// Widths, default sizes and datapath types shared by every RTL block

package core_cfg_pkg;

    // Datapath and register widths
    localparam int XLEN          = 32;
    localparam int ARCH_REGS     = 32;
    localparam int PHYS_TAG_BITS = 6;

    // Default sizes picked up by the top level
    localparam int DEFAULT_PHYS_REGS = 48;
    localparam int DEFAULT_ROB_DEPTH = 8;

    // Data word and raw instruction word
    typedef logic [XLEN-1:0] data_t;
    typedef logic [31:0]     inst_t;

    // Architected register index
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;

    // Physical register tag, room for up to 64 registers
    typedef logic [PHYS_TAG_BITS-1:0] phys_tag_t;

endpackage

// ==== hdl/rv_isa_pkg.sv ====
// RV32I encodings for the integer subset accepted by the core
// The decoder classifies against these and the ALU switches on alu_op_t

package rv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 values, same for register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct7 values, the alternate one selects sub and sra
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // ALU operations, pass forwards operand B for lui
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS
    } alu_op_t;

endpackage

// ==== hdl/decoder.sv ====
// Combinational decode of one RV32I instruction
// Yields the ALU operation, register fields, immediate and legality

module decoder (
    input  core_cfg_pkg::inst_t     inst,
    output rv_isa_pkg::alu_op_t     alu_op,
    output core_cfg_pkg::arch_reg_t rs1,
    output core_cfg_pkg::arch_reg_t rs2,
    output core_cfg_pkg::arch_reg_t rd,
    output core_cfg_pkg::data_t     imm,
    output logic                    use_imm,
    output logic                    has_dest,
    output logic                    illegal
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt_ok;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    // Only add/sub and the right shifts accept the alternate funct7
    assign alt_ok = (funct3 == F3_ADD && opcode == OPC_OP) || funct3 == F3_SR;

    always_comb begin
        // Defaults give an illegal add with the sign-extended I immediate
        alu_op  = ALU_ADD;
        imm     = {{20{inst[31]}}, inst[31:20]};
        use_imm = 1'b0;
        illegal = 1'b1;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                use_imm = (opcode == OPC_OP_IMM);
                illegal = 1'b0;
                case (funct3)
                    F3_ADD:  alu_op = (funct7 == F7_ALT && !use_imm) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_SLTU: alu_op = ALU_SLTU;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SR:   alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
                // Register forms and immediate shifts check funct7
                if (!use_imm || funct3 == F3_SLL || funct3 == F3_SR) begin
                    illegal = !(funct7 == F7_BASE || (funct7 == F7_ALT && alt_ok));
                end
                // Immediate shifts carry a plain shift amount
                if (use_imm && (funct3 == F3_SLL || funct3 == F3_SR)) begin
                    imm = {27'b0, inst[24:20]};
                end
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS;
                imm     = {inst[31:12], 12'b0};
                use_imm = 1'b1;
                illegal = 1'b0;
            end
            default: ;
        endcase
    end

    // x0 and illegal encodings write nothing
    assign has_dest = !illegal && rd != '0;

endmodule

// ==== hdl/rename.sv ====
// Register renaming for the core
// Speculative map read and written at dispatch, architected map and free list
// updated at retire

module rename #(
    parameter int PHYS_REGS = core_cfg_pkg::DEFAULT_PHYS_REGS
) (
    input  logic                    clock,
    input  logic                    rst,
    // Dispatch side
    input  core_cfg_pkg::arch_reg_t rs1,
    input  core_cfg_pkg::arch_reg_t rs2,
    input  logic                    alloc,
    input  logic                    has_dest,
    input  core_cfg_pkg::arch_reg_t rd,
    output core_cfg_pkg::phys_tag_t src1_tag,
    output core_cfg_pkg::phys_tag_t src2_tag,
    output core_cfg_pkg::phys_tag_t new_tag,
    output core_cfg_pkg::phys_tag_t old_tag,
    output logic                    tag_available,
    // Retire side
    input  logic                    retire_en,
    input  core_cfg_pkg::arch_reg_t retire_rd,
    input  core_cfg_pkg::phys_tag_t retire_old_tag,
    input  core_cfg_pkg::phys_tag_t retire_new_tag
);
    import core_cfg_pkg::*;

    // Free list never holds more than the spare registers
    localparam int FL_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FL_W     = (FL_DEPTH > 1) ? $clog2(FL_DEPTH) : 1;

    phys_tag_t       spec_map  [ARCH_REGS];
    phys_tag_t       arch_map  [ARCH_REGS];
    phys_tag_t       free_tags [FL_DEPTH];
    logic [FL_W-1:0] fl_rd_ptr;
    logic [FL_W-1:0] fl_wr_ptr;
    logic [FL_W:0]   fl_count;
    logic            pop;

    // Wrap at the free list depth, which need not be a power of two
    function automatic logic [FL_W-1:0] next_ptr(input logic [FL_W-1:0] ptr);
        return (ptr == FL_W'(FL_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Lookups at dispatch

    // Sources read the map before this cycle's own write lands
    assign src1_tag      = spec_map[rs1];
    assign src2_tag      = spec_map[rs2];
    assign old_tag       = spec_map[rd];
    assign new_tag       = free_tags[fl_rd_ptr];
    assign tag_available = fl_count != '0;
    assign pop           = alloc && has_dest;

    //////////////////////////////////////////////////
    // Map and free list update

    always_ff @(posedge clock) begin
        if (rst) begin
            // Identity maps, spare tags queued in order
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= phys_tag_t'(i);
                arch_map[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_tags[i] <= phys_tag_t'(ARCH_REGS + i);
            end
            fl_rd_ptr <= '0;
            fl_wr_ptr <= '0;
            fl_count  <= (FL_W+1)'(FL_DEPTH);
        end else begin
            if (pop) begin
                spec_map[rd] <= new_tag;
                fl_rd_ptr    <= next_ptr(fl_rd_ptr);
            end
            // Retired mapping becomes architected, its predecessor goes free
            if (retire_en) begin
                arch_map[retire_rd]  <= retire_new_tag;
                free_tags[fl_wr_ptr] <= retire_old_tag;
                fl_wr_ptr            <= next_ptr(fl_wr_ptr);
            end
            fl_count <= fl_count + {{FL_W{1'b0}}, retire_en} - {{FL_W{1'b0}}, pop};
        end
    end

    // Dispatch must be held off while no spare tag is left
    a_pop_not_empty: assert property (@(posedge clock) disable iff (rst)
        pop |-> fl_count != '0)
        else $error("free list popped while empty");

endmodule

// ==== hdl/rob.sv ====
// Circular reorder buffer
// Allocated at dispatch, marked complete by execute, retired in order from the head

module rob #(
    parameter int ROB_DEPTH = core_cfg_pkg::DEFAULT_ROB_DEPTH
) (
    input  logic                         clock,
    input  logic                         rst,
    // Allocation
    input  logic                         push,
    input  core_cfg_pkg::arch_reg_t      push_rd,
    input  core_cfg_pkg::phys_tag_t      push_new_tag,
    input  core_cfg_pkg::phys_tag_t      push_old_tag,
    input  logic                         push_has_dest,
    input  logic                         push_illegal,
    output logic [$clog2(ROB_DEPTH)-1:0] tail_idx,
    output logic                         full,
    // Completion
    input  logic                         complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] complete_idx,
    input  core_cfg_pkg::data_t          complete_data,
    // Retire
    input  logic                         retire_hold,
    output logic                         retire_en,
    output core_cfg_pkg::arch_reg_t      retire_rd,
    output core_cfg_pkg::phys_tag_t      retire_new_tag,
    output core_cfg_pkg::phys_tag_t      retire_old_tag,
    output logic                         retire_has_dest,
    output core_cfg_pkg::data_t          commit_data,
    output logic                         commit_illegal
);
    import core_cfg_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    // One array per entry field
    arch_reg_t        ent_rd       [ROB_DEPTH];
    phys_tag_t        ent_new_tag  [ROB_DEPTH];
    phys_tag_t        ent_old_tag  [ROB_DEPTH];
    logic             ent_has_dest [ROB_DEPTH];
    logic             ent_illegal  [ROB_DEPTH];
    logic             ent_complete [ROB_DEPTH];
    data_t            ent_data     [ROB_DEPTH];
    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [IDX_W:0]   count;
    logic [IDX_W-1:0] complete_offset;

    assign tail_idx  = tail;
    assign full      = count == (IDX_W+1)'(ROB_DEPTH);
    assign retire_en = count != '0 && ent_complete[head] && !retire_hold;

    // Head entry drives the retire outputs
    assign retire_rd       = ent_rd[head];
    assign retire_new_tag  = ent_new_tag[head];
    assign retire_old_tag  = ent_old_tag[head];
    assign retire_has_dest = ent_has_dest[head];
    assign commit_data     = ent_data[head];
    assign commit_illegal  = ent_illegal[head];

    // Pointers and occupancy
    always_ff @(posedge clock) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= tail + 1'b1;
            if (retire_en) head <= head + 1'b1;
            count <= count + {{IDX_W{1'b0}}, push} - {{IDX_W{1'b0}}, retire_en};
        end
    end

    // Entry payload, complete bit cleared on allocation
    always_ff @(posedge clock) begin
        if (push) begin
            ent_rd[tail]       <= push_rd;
            ent_new_tag[tail]  <= push_new_tag;
            ent_old_tag[tail]  <= push_old_tag;
            ent_has_dest[tail] <= push_has_dest;
            ent_illegal[tail]  <= push_illegal;
            ent_complete[tail] <= 1'b0;
        end
        if (complete_valid) begin
            ent_complete[complete_idx] <= 1'b1;
            // Nothing is reported for entries without a destination
            ent_data[complete_idx] <= ent_has_dest[complete_idx] ? complete_data : '0;
        end
    end

    // Distance of the completing entry from the head
    assign complete_offset = complete_idx - head;

    a_push_not_full: assert property (@(posedge clock) disable iff (rst)
        push |-> !full)
        else $error("ROB push while full");

    a_complete_occupied: assert property (@(posedge clock) disable iff (rst)
        complete_valid |-> {1'b0, complete_offset} < count)
        else $error("completion targets a free ROB entry");

endmodule

// ==== hdl/execute.sv ====
// Single ALU execute stage
// Issue register filled at dispatch, PRF read in the next cycle, result written
// back and reported to the ROB at the following edge

module execute #(
    parameter int PHYS_REGS = core_cfg_pkg::DEFAULT_PHYS_REGS,
    parameter int ROB_DEPTH = core_cfg_pkg::DEFAULT_ROB_DEPTH
) (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         issue,
    input  rv_isa_pkg::alu_op_t          alu_op,
    input  core_cfg_pkg::phys_tag_t      src1_tag,
    input  core_cfg_pkg::phys_tag_t      src2_tag,
    input  core_cfg_pkg::data_t          imm,
    input  logic                         use_imm,
    input  core_cfg_pkg::phys_tag_t      dest_tag,
    input  logic                         dest_en,
    input  logic [$clog2(ROB_DEPTH)-1:0] rob_idx,
    output logic                         complete_valid,
    output logic [$clog2(ROB_DEPTH)-1:0] complete_idx,
    output core_cfg_pkg::data_t          complete_data
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    // Issue register
    logic                         iss_valid;
    alu_op_t                      iss_op;
    phys_tag_t                    iss_src1;
    phys_tag_t                    iss_src2;
    data_t                        iss_imm;
    logic                         iss_use_imm;
    phys_tag_t                    iss_dest;
    logic                         iss_dest_en;
    logic [$clog2(ROB_DEPTH)-1:0] iss_rob_idx;

    data_t prf [PHYS_REGS];
    data_t opa;
    data_t opb;
    data_t result;

    always_ff @(posedge clock) begin
        if (rst) iss_valid <= 1'b0;
        else     iss_valid <= issue;
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            iss_op      <= alu_op;
            iss_src1    <= src1_tag;
            iss_src2    <= src2_tag;
            iss_imm     <= imm;
            iss_use_imm <= use_imm;
            iss_dest    <= dest_tag;
            iss_dest_en <= dest_en;
            iss_rob_idx <= rob_idx;
        end
    end

    //////////////////////////////////////////////////
    // Operand read and ALU

    assign opa = prf[iss_src1];
    assign opb = iss_use_imm ? iss_imm : prf[iss_src2];

    always_comb begin
        case (iss_op)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_AND:  result = opa & opb;
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_SLT:  result = {{XLEN-1{1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU: result = {{XLEN-1{1'b0}}, opa < opb};
            // Shifts use the low five bits only
            ALU_SLL:  result = opa << opb[4:0];
            ALU_SRL:  result = opa >> opb[4:0];
            ALU_SRA:  result = data_t'($signed(opa) >>> opb[4:0]);
            ALU_PASS: result = opb;
            default:  result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Writeback

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                prf[i] <= '0;
            end
        end else if (iss_valid && iss_dest_en) begin
            prf[iss_dest] <= result;
        end
    end

    // ROB sees the result in the same cycle it is written
    assign complete_valid = iss_valid;
    assign complete_idx   = iss_rob_idx;
    assign complete_data  = result;

    // Tag 0 holds x0 and must stay zero
    a_no_tag0_write: assert property (@(posedge clock) disable iff (rst)
        (iss_valid && iss_dest_en) |-> iss_dest != '0)
        else $error("write to physical tag 0");

endmodule

// ==== hdl/cpu.sv ====
// Top level of the scalar renaming core
// Accepts one instruction per cycle on inst_valid/inst_ready, commits in order
// on the commit port, retire_hold stalls commit

module cpu #(
    parameter int PHYS_REGS = core_cfg_pkg::DEFAULT_PHYS_REGS,
    parameter int ROB_DEPTH = core_cfg_pkg::DEFAULT_ROB_DEPTH
) (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    inst_valid,
    input  core_cfg_pkg::inst_t     inst,
    output logic                    inst_ready,
    input  logic                    retire_hold,
    output logic                    commit_valid,
    output core_cfg_pkg::arch_reg_t commit_rd,
    output core_cfg_pkg::data_t     commit_data,
    output logic                    commit_illegal
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    // Decode outputs
    alu_op_t    dec_op;
    arch_reg_t  dec_rs1;
    arch_reg_t  dec_rs2;
    arch_reg_t  dec_rd;
    data_t      dec_imm;
    logic       dec_use_imm;
    logic       dec_has_dest;
    logic       dec_illegal;
    // Rename outputs
    phys_tag_t  src1_tag;
    phys_tag_t  src2_tag;
    phys_tag_t  new_tag;
    phys_tag_t  old_tag;
    logic       tag_available;
    // ROB and execute
    logic [IDX_W-1:0] tail_idx;
    logic             rob_full;
    logic             complete_valid;
    logic [IDX_W-1:0] complete_idx;
    data_t            complete_data;
    logic             retire_en;
    arch_reg_t        retire_rd;
    phys_tag_t        retire_new_tag;
    phys_tag_t        retire_old_tag;
    logic             retire_has_dest;
    logic             accept;

    // Room in the ROB and a spare tag are both needed to dispatch
    assign inst_ready = !rob_full && tag_available;
    assign accept     = inst_valid && inst_ready;

    //////////////////////////////////////////////////
    // Decode and rename

    decoder u_decoder (
        .inst(inst), .alu_op(dec_op), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .imm(dec_imm), .use_imm(dec_use_imm), .has_dest(dec_has_dest),
        .illegal(dec_illegal)
    );

    rename #(.PHYS_REGS(PHYS_REGS)) u_rename (
        .clock(clock), .rst(rst), .rs1(dec_rs1), .rs2(dec_rs2), .alloc(accept),
        .has_dest(dec_has_dest), .rd(dec_rd), .src1_tag(src1_tag), .src2_tag(src2_tag),
        .new_tag(new_tag), .old_tag(old_tag), .tag_available(tag_available),
        .retire_en(retire_en && retire_has_dest), .retire_rd(retire_rd),
        .retire_old_tag(retire_old_tag), .retire_new_tag(retire_new_tag)
    );

    //////////////////////////////////////////////////
    // Reorder buffer and execute

    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clock(clock), .rst(rst), .push(accept), .push_rd(dec_rd),
        .push_new_tag(new_tag), .push_old_tag(old_tag), .push_has_dest(dec_has_dest),
        .push_illegal(dec_illegal), .tail_idx(tail_idx), .full(rob_full),
        .complete_valid(complete_valid), .complete_idx(complete_idx),
        .complete_data(complete_data), .retire_hold(retire_hold),
        .retire_en(retire_en), .retire_rd(retire_rd), .retire_new_tag(retire_new_tag),
        .retire_old_tag(retire_old_tag), .retire_has_dest(retire_has_dest),
        .commit_data(commit_data), .commit_illegal(commit_illegal)
    );

    execute #(.PHYS_REGS(PHYS_REGS), .ROB_DEPTH(ROB_DEPTH)) u_execute (
        .clock(clock), .rst(rst), .issue(accept), .alu_op(dec_op),
        .src1_tag(src1_tag), .src2_tag(src2_tag), .imm(dec_imm), .use_imm(dec_use_imm),
        .dest_tag(new_tag), .dest_en(dec_has_dest), .rob_idx(tail_idx),
        .complete_valid(complete_valid), .complete_idx(complete_idx),
        .complete_data(complete_data)
    );

    // Commit port, rd reads as 0 when nothing was written
    assign commit_valid = retire_en;
    assign commit_rd    = retire_has_dest ? retire_rd : '0;

endmodule

// ==== testbench/cpu_checker.sv ====
// Reference model and scoreboard for the core
// Queues every accepted instruction and, on each commit, executes the oldest
// one on a 32-register model and compares the commit port against it

module cpu_checker #(
    parameter int ROB_DEPTH = core_cfg_pkg::DEFAULT_ROB_DEPTH
) (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    inst_valid,
    input  core_cfg_pkg::inst_t     inst,
    input  logic                    inst_ready,
    input  logic                    retire_hold,
    input  logic                    commit_valid,
    input  core_cfg_pkg::arch_reg_t commit_rd,
    input  core_cfg_pkg::data_t     commit_data,
    input  logic                    commit_illegal,
    output int                      checks,
    output int                      errors,
    output int                      timing_errors,
    output int                      pending
);
    import core_cfg_pkg::*;

    inst_t  q_inst  [$];
    longint q_cycle [$];
    data_t  regs    [32];
    longint cycle;

    //////////////////////////////////////////////////
    // Architectural model

    function automatic data_t alu_result(input logic [2:0] f3, input logic alt,
                                         input data_t a, input data_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Expected commit port for one instruction against the current model
    function automatic void predict(input inst_t w, output arch_reg_t e_rd,
                                    output data_t e_data, output logic e_ill);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        data_t      a;
        data_t      b;
        logic       alt;
        logic       legal;
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = regs[w[19:15]];
        b     = regs[w[24:20]];
        alt   = 1'b0;
        legal = 1'b0;
        case (opc)
            7'b0110011: begin
                legal = f7 == 7'b0 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
                alt   = f7[5];
            end
            7'b0010011: begin
                b = {{20{w[31]}}, w[31:20]};
                if (f3 == 3'b001) legal = f7 == 7'b0;
                else if (f3 == 3'b101) legal = f7 == 7'b0 || f7 == 7'b0100000;
                else legal = 1'b1;
                alt = (f3 == 3'b101) && f7[5];
            end
            7'b0110111: legal = 1'b1;
            default:    legal = 1'b0;
        endcase
        e_data = (opc == 7'b0110111) ? {w[31:12], 12'b0} : alu_result(f3, alt, a, b);
        e_ill  = !legal;
        e_rd   = legal ? w[11:7] : 5'd0;
        // Nothing written means nothing reported
        if (e_rd == 5'd0) e_data = '0;
    endfunction

    task automatic check_field(input string what, input data_t expected, input data_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, what,
                     expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Sampling at each rising edge

    always @(posedge clock) begin
        inst_t     w;
        longint    acc;
        arch_reg_t e_rd;
        data_t     e_data;
        logic      e_ill;
        if (rst) begin
            q_inst.delete();
            q_cycle.delete();
            for (int i = 0; i < 32; i++) regs[i] = '0;
            cycle   = 0;
            pending = 0;
        end else begin
            cycle++;
            if (commit_valid && retire_hold) begin
                errors++;
                $display("ERROR at %0t: commit while retire_hold was high", $time);
            end
            if (commit_valid && q_inst.size() == 0) begin
                errors++;
                $display("ERROR at %0t: commit with no instruction outstanding", $time);
            end else if (commit_valid) begin
                w   = q_inst.pop_front();
                acc = q_cycle.pop_front();
                // Two rising edges from accept to commit at the earliest
                if (cycle - acc < 2) begin
                    errors++;
                    timing_errors++;
                    $display("ERROR at %0t: commit %0d edges after accept, too early",
                             $time, cycle - acc);
                end
                predict(w, e_rd, e_data, e_ill);
                check_field("commit_rd", 32'(e_rd), 32'(commit_rd));
                check_field("commit_data", e_data, commit_data);
                check_field("commit_illegal", 32'(e_ill), 32'(commit_illegal));
                if (e_rd != 5'd0) regs[e_rd] = e_data;
            end
            if (inst_valid && inst_ready) begin
                q_inst.push_back(inst);
                q_cycle.push_back(cycle);
            end
            // Accepted but not committed can never exceed the ROB
            if (q_inst.size() > ROB_DEPTH) begin
                errors++;
                $display("ERROR at %0t: %0d instructions in flight, more than the ROB holds",
                         $time, q_inst.size());
            end
            pending = q_inst.size();
        end
    end

endmodule

// ==== testbench/cpu_tb.sv ====
// Testbench top for the renaming core
// Drives seeded random RV32I instructions in one phase per behavior
// and prints one result line per test plus a closing summary

module cpu_tb;
    import core_cfg_pkg::*;

    localparam int PHYS_REGS = DEFAULT_PHYS_REGS;
    localparam int ROB_DEPTH = DEFAULT_ROB_DEPTH;
    localparam int TOTAL     = 2000;

    // Stimulus modes
    localparam int M_RR   = 0;
    localparam int M_IMM  = 1;
    localparam int M_MIX  = 2;
    localparam int M_ILL  = 3;
    localparam int M_HOLD = 4;

    logic      clock;
    logic      rst;
    logic      inst_valid;
    inst_t     inst;
    logic      inst_ready;
    logic      retire_hold;
    logic      commit_valid;
    arch_reg_t commit_rd;
    data_t     commit_data;
    logic      commit_illegal;
    int        checks;
    int        errors;
    int        timing_errors;
    int        pending;
    int        seed = 32'hf8bfd43f;
    int        tests_passed;
    int        tests_failed;

    cpu #(.PHYS_REGS(PHYS_REGS), .ROB_DEPTH(ROB_DEPTH)) uut (
        .clock(clock), .rst(rst), .inst_valid(inst_valid), .inst(inst),
        .inst_ready(inst_ready), .retire_hold(retire_hold), .commit_valid(commit_valid),
        .commit_rd(commit_rd), .commit_data(commit_data), .commit_illegal(commit_illegal)
    );

    cpu_checker #(.ROB_DEPTH(ROB_DEPTH)) u_checker (
        .clock(clock), .rst(rst), .inst_valid(inst_valid), .inst(inst),
        .inst_ready(inst_ready), .retire_hold(retire_hold), .commit_valid(commit_valid),
        .commit_rd(commit_rd), .commit_data(commit_data), .commit_illegal(commit_illegal),
        .checks(checks), .errors(errors), .timing_errors(timing_errors), .pending(pending)
    );

    always #10 clock = ~clock;

    //////////////////////////////////////////////////
    // Instruction generation

    function automatic int unsigned roll(input int unsigned range);
        return $unsigned($random(seed)) % range;
    endfunction

    // Mostly x0..x7 so that back-to-back dependences are common
    function automatic logic [4:0] pick_reg();
        return (roll(16) < 13) ? 5'(roll(8)) : 5'(roll(32));
    endfunction

    function automatic inst_t reg_reg_op();
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = 3'(roll(8));
        // sub and sra use the alternate funct7
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && roll(2) == 1) ? 7'b0100000 : 7'b0000000;
        return {f7, pick_reg(), pick_reg(), f3, pick_reg(), 7'b0110011};
    endfunction

    function automatic inst_t imm_op();
        logic [2:0]  f3;
        logic [11:0] imm;
        if (roll(100) < 20) begin
            return {20'(roll(32'hffff_ffff)), pick_reg(), 7'b0110111};
        end
        f3  = 3'(roll(8));
        imm = 12'(roll(4096));
        // Shift immediates carry a shift amount and a funct7
        if (f3 == 3'b001) imm[11:5] = 7'b0000000;
        if (f3 == 3'b101) imm[11:5] = (roll(2) == 1) ? 7'b0100000 : 7'b0000000;
        return {imm, pick_reg(), f3, pick_reg(), 7'b0010011};
    endfunction

    function automatic inst_t illegal_word();
        inst_t w;
        if (roll(2) == 1) begin
            // Kept opcode whose funct7 has bit 0 set and matches no operation
            w     = reg_reg_op();
            w[25] = 1'b1;
            // Part of them become immediate shifts
            if (roll(2) == 1) begin
                w[6:0]   = 7'b0010011;
                w[14:12] = (roll(2) == 1) ? 3'b001 : 3'b101;
            end
            return w;
        end
        // Random word pushed off the three kept opcodes
        w = inst_t'(roll(32'hffff_ffff));
        if (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011 || w[6:0] == 7'b0110111) begin
            w[6] = ~w[6];
        end
        return w;
    endfunction

    function automatic inst_t draw_inst(input int mode);
        int    pick;
        inst_t w;
        pick = int'(roll(100));
        case (mode)
            M_RR:    w = reg_reg_op();
            M_IMM:   w = imm_op();
            M_ILL:   begin
                if (pick < 40) w = illegal_word();
                else w = (pick < 70) ? reg_reg_op() : imm_op();
                // Part of the legal ones target x0
                if (pick >= 40 && roll(2) == 1) w[11:7] = 5'd0;
            end
            default: begin
                if (pick < 5) w = illegal_word();
                else w = (pick < 50) ? reg_reg_op() : imm_op();
            end
        endcase
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Phase driver

    task automatic run_test(input int id, input string name, input int mode, input int n);
        int   accepted;
        int   cyc;
        int   err_start;
        logic offered;
        logic have;
        accepted  = 0;
        cyc       = 0;
        offered   = 1'b0;
        have      = 1'b0;
        err_start = errors;
        while (accepted < n) begin
            @(negedge clock);
            cyc++;
            // Offer made in the last half cycle was taken at the rising edge
            if (offered) begin
                accepted++;
                have = 1'b0;
            end
            offered = 1'b0;
            if (accepted < n) begin
                if (!have) begin
                    inst = draw_inst(mode);
                    have = 1'b1;
                end
                if (mode == M_HOLD) retire_hold = (cyc % 40) < 20;
                inst_valid = retire_hold ? 1'b1 : (roll(100) < 80);
                // inst_ready depends on state only, so it holds until the edge
                offered = inst_valid && inst_ready;
            end else begin
                inst_valid = 1'b0;
            end
        end
        @(negedge clock);
        inst_valid  = 1'b0;
        retire_hold = 1'b0;
        // Drain everything still in flight
        while (pending != 0) @(negedge clock);
        if (errors == err_start) tests_passed++;
        else tests_failed++;
        $display("test %0d %s: %s (%0d errors)", id, name,
                 (errors == err_start) ? "PASS" : "FAIL", errors - err_start);
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        clock        = 1'b0;
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        retire_hold  = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        run_test(1, "register-register ALU", M_RR, 300);
        run_test(2, "immediate ALU and lui", M_IMM, 300);
        run_test(3, "dependent chains", M_MIX, 900);
        run_test(4, "illegal and x0", M_ILL, 300);
        run_test(5, "retire hold", M_HOLD, 200);
        if (timing_errors == 0) tests_passed++;
        else tests_failed++;
        $display("test 6 commit order and latency: %s (%0d errors)",
                 (timing_errors == 0) ? "PASS" : "FAIL", timing_errors);
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the instruction count
    initial begin
        #(20 * TOTAL * 4);
        $display("Timeout: the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/core_cfg_pkg.sv
hdl/rv_isa_pkg.sv
hdl/decoder.sv
hdl/rename.sv
hdl/rob.sv
hdl/execute.sv
hdl/cpu.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cpu_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
